// ==== Bender.yml ====
package:
  name: vga_frame_buffer

export_include_dirs:
  - source

sources:
  - files:
      - source/vga_pkg.sv
      - source/vga_mem.sv
      - source/core_access_fsm.sv
      - source/vga_sync_timer.sv
      - source/pixel_fetch.sv
      - source/vga_top.sv
  - target: test
    files:
      - verification/vga_tb.sv

// ==== source/core_access_fsm.sv ====
//==================================================
// Core access FSM
// Serves four-phase req/ack requests from the core
// on port a of the video memory
//==================================================
`include "vga_defs.svh"

module core_access_fsm (
    input  logic                        clock,
    input  logic                        arst_n,
    // Core side
    input  logic                        req,
    input  vga_pkg::core_req_t          req_data,
    output logic                        ack,
    output vga_pkg::core_rsp_t          rsp,
    // Memory port a
    output logic                        wren_a,
    output logic [`VGA_WORD_ADDR_W-1:0] address_a,
    output logic [3:0]                  byteena_a,
    output logic [31:0]                 data_a,
    input  logic [31:0]                 q_a
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WAIT_Q,
        ACKED
    } state_t;

    state_t             state;
    state_t             state_nxt;
    // Command captured when req is first seen
    vga_pkg::core_req_t req_q;

    //==================================================
    // State register and next state
    //==================================================
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (req) begin
                    state_nxt = ACCESS;
                end
            end
            // Memory is hit on this edge
            ACCESS: state_nxt = WAIT_Q;
            // q_a valid, ack goes up on this edge
            WAIT_Q: state_nxt = ACKED;
            // Wait for the core to release req
            ACKED: begin
                if (!req) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    // Command latch
    always_ff @(posedge clock) begin
        if (state == IDLE && req) begin
            req_q <= req_data;
        end
    end

    //==================================================
    // Memory port
    //==================================================
    assign address_a = req_q.addr;
    assign byteena_a = req_q.byteena;
    assign data_a    = req_q.wdata;
    // Single store pulse in ACCESS
    assign wren_a    = (state == ACCESS) && req_q.we;

    //==================================================
    // Handshake and response
    //==================================================
    // Set leaving WAIT_Q, cleared one edge after IDLE is entered
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ack <= 1'b0;
        end else if (state == WAIT_Q) begin
            ack <= 1'b1;
        end else if (state == IDLE) begin
            ack <= 1'b0;
        end
    end

    // Load data held until the next access
    always_ff @(posedge clock) begin
        if (state == WAIT_Q) begin
            rsp.rdata <= q_a;
        end
    end

    //==================================================
    // Checks
    //==================================================
    // Core keeps the command steady until acked
    a_req_stable : assert property (
        @(posedge clock) disable iff (!arst_n)
        ($past(req) && req && !ack) |-> $stable(req_data)
    ) else $error("req_data changed before ack");

    // No ack without a pending request
    a_ack_after_req : assert property (
        @(posedge clock) disable iff (!arst_n)
        $rose(ack) |-> $past(req)
    ) else $error("ack raised without req");

endmodule

// ==== source/pixel_fetch.sv ====
//==================================================
// Pixel fetch
// Reads the display port for the current raster
// point and shifts out one pixel per clock with
// the syncs, two cycles behind the timer
//==================================================
`include "vga_defs.svh"

module pixel_fetch (
    input  logic                        clock,
    input  logic                        arst_n,
    input  vga_pkg::raster_pos_t        pos,
    // Memory port b
    output logic [`VGA_WORD_ADDR_W-1:0] address_b,
    input  logic [31:0]                 q_b,
    // Video out
    output logic                        pixel,
    output logic                        hsync,
    output logic                        vsync
);

    // Stage 1, aligned with q_b
    logic [4:0] bit_sel_d;
    logic       visible_d;
    logic       hsync_d;
    logic       vsync_d;
    // Selected pixel from the word
    logic       pix_bit;

    //==================================================
    // Address
    //==================================================
    // Line base plus word within the line
    assign address_b = `VGA_WORD_ADDR_W'(pos.y * `VGA_WORDS_PER_LINE)
                     + `VGA_WORD_ADDR_W'(pos.x[9:5]);

    //==================================================
    // Stage 1, wait for the memory
    //==================================================
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            visible_d <= 1'b0;
            hsync_d   <= 1'b1;
            vsync_d   <= 1'b1;
        end else begin
            visible_d <= pos.visible;
            hsync_d   <= pos.hsync;
            vsync_d   <= pos.vsync;
        end
    end

    // Pixel index within the word, no reset needed
    always_ff @(posedge clock) begin
        bit_sel_d <= pos.x[4:0];
    end

    // Bit 0 is the leftmost pixel
    assign pix_bit = q_b[bit_sel_d];

    //==================================================
    // Stage 2, output registers
    //==================================================
    // Blanking forces black
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pixel <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            pixel <= visible_d && pix_bit;
            hsync <= hsync_d;
            vsync <= vsync_d;
        end
    end

endmodule

// ==== source/vga_defs.svh ====
//==================================================
// VGA frame buffer defines
// Raster timing of the 640x480 frame, video memory
// size and address widths
//==================================================
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

//==================================================
// Horizontal timing, in clock cycles
//==================================================
// Active pixels per line
`define VGA_H_VISIBLE 640
// Blank before the sync pulse
`define VGA_H_FRONT 16
// Sync pulse width
`define VGA_H_SYNC 96
// Full line incl. back porch
`define VGA_H_TOTAL 800

//==================================================
// Vertical timing, in lines
//==================================================
`define VGA_V_VISIBLE 480
`define VGA_V_FRONT 10
`define VGA_V_SYNC 2
`define VGA_V_TOTAL 525

//==================================================
// Video memory geometry
//==================================================
// 80 bytes x 480 lines, one bit per pixel
`define VGA_MEM_BYTES 38400
// Word count of the same array
`define VGA_MEM_WORDS (`VGA_MEM_BYTES / 4)
// 32-bit words per display line
`define VGA_WORDS_PER_LINE 20
// Word address as seen by both ports
`define VGA_WORD_ADDR_W 14

`endif

// ==== source/vga_mem.sv ====
//==================================================
// Video memory
// Two-port byte array, 1 bpp, 80 bytes per line
// Port a: core load/store with byte enables
// Port b: read only, feeds the pixel fetch
//==================================================
`include "vga_defs.svh"

module vga_mem (
    input  logic                        clock,
    // Core port
    input  logic                        wren_a,
    input  logic [`VGA_WORD_ADDR_W-1:0] address_a,
    input  logic [3:0]                  byteena_a,
    input  logic [31:0]                 data_a,
    output logic [31:0]                 q_a,
    // Display port
    input  logic [`VGA_WORD_ADDR_W-1:0] address_b,
    output logic [31:0]                 q_b
);

    // Storage kept in bytes like the FPGA block
    logic [7:0] mem [0:`VGA_MEM_BYTES-1];

    // Byte address of the first byte in each word
    logic [`VGA_WORD_ADDR_W+1:0] byte_addr_a;
    logic [`VGA_WORD_ADDR_W+1:0] byte_addr_b;

    assign byte_addr_a = {address_a, 2'b00};
    assign byte_addr_b = {address_b, 2'b00};

    //==================================================
    // Store
    //==================================================
    // Only enabled lanes change
    always_ff @(posedge clock) begin
        if (wren_a) begin
            for (int i = 0; i < 4; i++) begin
                if (byteena_a[i]) begin
                    mem[byte_addr_a + i] <= data_a[8*i +: 8];
                end
            end
        end
    end

    //==================================================
    // Registered reads
    //==================================================
    // Nonblocking update, so a same-cycle read sees old data
    always_ff @(posedge clock) begin
        q_a <= {mem[byte_addr_a + 3], mem[byte_addr_a + 2],
                mem[byte_addr_a + 1], mem[byte_addr_a + 0]};
    end

    // Display read, one word of 32 pixels
    always_ff @(posedge clock) begin
        q_b <= {mem[byte_addr_b + 3], mem[byte_addr_b + 2],
                mem[byte_addr_b + 1], mem[byte_addr_b + 0]};
    end

    //==================================================
    // Checks
    //==================================================
    // Stores stay inside the frame
    a_store_in_range : assert property (
        @(posedge clock) wren_a |-> (address_a < `VGA_MEM_WORDS)
    ) else $error("store outside video memory, word %0d", address_a);

endmodule

// ==== source/vga_pkg.sv ====
//==================================================
// VGA frame buffer package
// Core access command, read response and the
// raster position shared by timer and fetch
//==================================================
`include "vga_defs.svh"

package vga_pkg;

    //==================================================
    // Core port
    //==================================================

    // Access command, held stable by the core while req is up
    typedef struct packed {
        // 1 for store, 0 for load
        logic                        we;
        // Word address into video memory
        logic [`VGA_WORD_ADDR_W-1:0] addr;
        // Byte 0 maps to wdata[7:0]
        logic [3:0]                  byteena;
        logic [31:0]                 wdata;
    } core_req_t;

    // Load data, valid while ack is high
    typedef struct packed {
        logic [31:0] rdata;
    } core_rsp_t;

    //==================================================
    // Raster scan point
    //==================================================

    // Syncs are active low as on the connector
    typedef struct packed {
        // Column 0..799
        logic [9:0] x;
        // Line 0..524
        logic [9:0] y;
        // Inside the 640x480 area
        logic       visible;
        logic       hsync;
        logic       vsync;
    } raster_pos_t;

endpackage

// ==== source/vga_sync_timer.sv ====
//==================================================
// VGA sync timer
// Free-running raster counters over the 800x525
// frame, with visible and sync flags
//==================================================
`include "vga_defs.svh"

module vga_sync_timer (
    input  logic                 clock,
    input  logic                 arst_n,
    output vga_pkg::raster_pos_t pos
);

    // Sync pulse windows, inclusive bounds
    localparam int H_SYNC_FIRST = `VGA_H_VISIBLE + `VGA_H_FRONT;
    localparam int H_SYNC_LAST  = H_SYNC_FIRST + `VGA_H_SYNC - 1;
    localparam int V_SYNC_FIRST = `VGA_V_VISIBLE + `VGA_V_FRONT;
    localparam int V_SYNC_LAST  = V_SYNC_FIRST + `VGA_V_SYNC - 1;

    logic [9:0] x;
    logic [9:0] y;
    // Last column of the line
    logic       x_wrap;
    // Last line of the frame
    logic       y_wrap;

    assign x_wrap = (x == 10'(`VGA_H_TOTAL - 1));
    assign y_wrap = (y == 10'(`VGA_V_TOTAL - 1));

    //==================================================
    // Counters
    //==================================================
    // Column, one step per clock
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            x <= '0;
        end else if (x_wrap) begin
            x <= '0;
        end else begin
            x <= x + 10'd1;
        end
    end

    // Line, steps on each column wrap
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            y <= '0;
        end else if (x_wrap) begin
            if (y_wrap) begin
                y <= '0;
            end else begin
                y <= y + 10'd1;
            end
        end
    end

    //==================================================
    // Flags
    //==================================================
    assign pos.x       = x;
    assign pos.y       = y;
    assign pos.visible = (x < 10'(`VGA_H_VISIBLE)) && (y < 10'(`VGA_V_VISIBLE));
    // Active low pulses
    assign pos.hsync   = !((x >= 10'(H_SYNC_FIRST)) && (x <= 10'(H_SYNC_LAST)));
    assign pos.vsync   = !((y >= 10'(V_SYNC_FIRST)) && (y <= 10'(V_SYNC_LAST)));

    //==================================================
    // Checks
    //==================================================
    // Column wraps before the line length
    a_x_in_line : assert property (
        @(posedge clock) disable iff (!arst_n)
        x < 10'(`VGA_H_TOTAL)
    ) else $error("raster x out of range: %0d", x);

endmodule

// ==== source/vga_top.sv ====
//==================================================
// VGA frame buffer top
// Core req/ack port, video memory, raster timer
// and pixel fetch on a single clock
//==================================================
`include "vga_defs.svh"

module vga_top (
    input  logic               clock,
    input  logic               arst_n,
    // Core port
    input  logic               req,
    input  vga_pkg::core_req_t req_data,
    output logic               ack,
    output vga_pkg::core_rsp_t rsp,
    // Video out
    output logic               pixel,
    output logic               hsync,
    output logic               vsync
);

    // Memory port a
    logic                        wren_a;
    logic [`VGA_WORD_ADDR_W-1:0] address_a;
    logic [3:0]                  byteena_a;
    logic [31:0]                 data_a;
    logic [31:0]                 q_a;
    // Memory port b
    logic [`VGA_WORD_ADDR_W-1:0] address_b;
    logic [31:0]                 q_b;
    // Scan point
    vga_pkg::raster_pos_t        pos;

    //==================================================
    // Core side
    //==================================================
    core_access_fsm u_core_access_fsm (
        .clock     (clock),
        .arst_n    (arst_n),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .rsp       (rsp),
        .wren_a    (wren_a),
        .address_a (address_a),
        .byteena_a (byteena_a),
        .data_a    (data_a),
        .q_a       (q_a)
    );

    vga_mem u_vga_mem (
        .clock     (clock),
        .wren_a    (wren_a),
        .address_a (address_a),
        .byteena_a (byteena_a),
        .data_a    (data_a),
        .q_a       (q_a),
        .address_b (address_b),
        .q_b       (q_b)
    );

    //==================================================
    // Display side
    //==================================================
    vga_sync_timer u_vga_sync_timer (
        .clock  (clock),
        .arst_n (arst_n),
        .pos    (pos)
    );

    pixel_fetch u_pixel_fetch (
        .clock     (clock),
        .arst_n    (arst_n),
        .pos       (pos),
        .address_b (address_b),
        .q_b       (q_b),
        .pixel     (pixel),
        .hsync     (hsync),
        .vsync     (vsync)
    );

endmodule

// ==== src.f ====
+incdir+source
source/vga_pkg.sv
source/vga_mem.sv
source/core_access_fsm.sv
source/vga_sync_timer.sv
source/pixel_fetch.sv
source/vga_top.sv
verification/vga_tb.sv

// ==== verification/vga_tb.sv ====
//==================================================
// VGA frame buffer testbench
// Random core accesses against a byte model of the
// video memory, raster model for syncs and pixels
//==================================================
`include "vga_defs.svh"

module vga_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned SEED         = 32'h711f5763;
    localparam int          FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
    localparam int          ACK_TIMEOUT  = 16;
    localparam int          FRAME_WORDS  = `VGA_V_VISIBLE * `VGA_WORDS_PER_LINE;

    logic                 clock;
    logic                 arst_n;
    logic                 req;
    vga_pkg::core_req_t   req_data;
    logic                 ack;
    vga_pkg::core_rsp_t   rsp;
    logic                 pixel;
    logic                 hsync;
    logic                 vsync;

    // Byte model, X until written like the DUT array
    logic [7:0] model_mem [0:`VGA_MEM_BYTES-1];

    // Raster model, current point and two-cycle history
    int mx;
    int my;
    int x_d1;
    int y_d1;
    int x_d2;
    int y_d2;

    // Score
    int errors;
    int checks;
    int tests;
    int test_errors;
    int test_checks;

    vga_top i_dut (
        .clock    (clock),
        .arst_n   (arst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp),
        .pixel    (pixel),
        .hsync    (hsync),
        .vsync    (vsync)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    //==================================================
    // Raster model
    //==================================================
    // x_d2/y_d2 is the point the video outputs show now
    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mx   <= 0;
            my   <= 0;
            x_d1 <= 0;
            y_d1 <= 0;
            x_d2 <= 0;
            y_d2 <= 0;
        end else begin
            x_d1 <= mx;
            y_d1 <= my;
            x_d2 <= x_d1;
            y_d2 <= y_d1;
            if (mx == `VGA_H_TOTAL - 1) begin
                mx <= 0;
                my <= (my == `VGA_V_TOTAL - 1) ? 0 : my + 1;
            end else begin
                mx <= mx + 1;
            end
        end
    end

    function automatic logic exp_hsync(int x);
        return !(x >= `VGA_H_VISIBLE + `VGA_H_FRONT &&
                 x <  `VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC);
    endfunction

    function automatic logic exp_vsync(int y);
        return !(y >= `VGA_V_VISIBLE + `VGA_V_FRONT &&
                 y <  `VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC);
    endfunction

    // Bit 0 of a word is its leftmost pixel
    function automatic logic exp_pixel(int x, int y);
        int word;
        int b;
        if (x >= `VGA_H_VISIBLE || y >= `VGA_V_VISIBLE) begin
            return 1'b0;
        end
        word = y * `VGA_WORDS_PER_LINE + x / 32;
        b    = x % 32;
        return model_mem[word * 4 + b / 8][b % 8];
    endfunction

    //==================================================
    // Compare tasks
    //==================================================
    task automatic check_rsp(vga_pkg::core_rsp_t got, vga_pkg::core_rsp_t exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: rsp.rdata got %h expected %h",
                     $time, got.rdata, exp.rdata);
            errors++;
        end
    endtask

    task automatic check_pixel(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: pixel got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_hsync(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: hsync got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_vsync(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: vsync got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_ack(logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: ack got %b expected %b", $time, got, exp);
            errors++;
        end
    endtask

    // Cycle counts and pulse widths
    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_idle_outputs();
        check_ack(ack, 1'b0);
        check_pixel(pixel, 1'b0);
        check_hsync(hsync, 1'b1);
        check_vsync(vsync, 1'b1);
    endtask

    task automatic start_test();
        test_errors = errors;
        test_checks = checks;
    endtask

    task automatic report_test(string name);
        tests++;
        $display("test %-10s checks %0d, errors %0d", name,
                 checks - test_checks, errors - test_errors);
    endtask

    //==================================================
    // Core port driver
    //==================================================
    // One four-phase transfer, req held for hold extra cycles after ack
    task automatic core_access(vga_pkg::core_req_t cmd, int hold);
        vga_pkg::core_rsp_t exp;
        int n;
        for (int w = 0; w < 4; w++) begin
            exp.rdata[8*w +: 8] = model_mem[int'(cmd.addr) * 4 + w];
        end
        @(posedge clock);
        req      <= 1'b1;
        req_data <= cmd;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!ack && n < ACK_TIMEOUT);
        if (!ack) begin
            $display("error at %0t ns: no ack for the request at word %0d", $time, cmd.addr);
            errors++;
        end else begin
            // First negedge comes before the edge that samples req
            check_count("ack rise latency", n - 2, 2);
            if (cmd.we) begin
                for (int w = 0; w < 4; w++) begin
                    if (cmd.byteena[w]) begin
                        model_mem[int'(cmd.addr) * 4 + w] = cmd.wdata[8*w +: 8];
                    end
                end
            end else begin
                check_rsp(rsp, exp);
            end
        end
        // Back-pressure from the core
        for (int i = 0; i < hold; i++) begin
            @(negedge clock);
            check_ack(ack, 1'b1);
        end
        @(posedge clock);
        req <= 1'b0;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (ack && n < ACK_TIMEOUT);
        if (ack) begin
            $display("error at %0t ns: ack stayed high after req dropped", $time);
            errors++;
        end else begin
            check_count("ack fall latency", n - 2, 1);
        end
    endtask

    task automatic random_access(bit we, int hold);
        vga_pkg::core_req_t cmd;
        cmd.we      = we;
        cmd.addr    = 14'($urandom_range(63));
        cmd.byteena = 4'($urandom);
        cmd.wdata   = $urandom;
        core_access(cmd, hold);
    endtask

    //==================================================
    // Frame checks
    //==================================================
    task automatic wait_frame_start();
        int n;
        n = 0;
        @(negedge clock);
        while (!(x_d2 == 0 && y_d2 == 0) && n < FRAME_CYCLES + 8) begin
            @(negedge clock);
            n++;
        end
        if (!(x_d2 == 0 && y_d2 == 0)) begin
            $display("error at %0t ns: raster never reached the frame start", $time);
            errors++;
        end
    endtask

    // One frame from the current negedge at point 0,0
    task automatic check_frame(bit with_pixel);
        int hs_run;
        int vs_lines;
        hs_run   = 0;
        vs_lines = 0;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            check_hsync(hsync, exp_hsync(x_d2));
            check_vsync(vsync, exp_vsync(y_d2));
            if (with_pixel) begin
                check_pixel(pixel, exp_pixel(x_d2, y_d2));
            end
            if (!hsync) begin
                hs_run++;
            end
            if (!vsync && x_d2 == 0) begin
                vs_lines++;
            end
            // Width of the pulse, line by line
            if (x_d2 == `VGA_H_TOTAL - 1) begin
                if (hs_run != `VGA_H_SYNC) begin
                    check_count("hsync low cycles", hs_run, `VGA_H_SYNC);
                end
                hs_run = 0;
            end
            @(negedge clock);
        end
        check_count("vsync low lines", vs_lines, `VGA_V_SYNC);
    endtask

    //==================================================
    // Test sequence
    //==================================================
    initial begin
        vga_pkg::core_req_t cmd;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        arst_n   = 1'b0;
        req      = 1'b0;
        req_data = '0;
        void'($urandom(SEED));

        // Reset state, during and just after release
        start_test();
        repeat (3) begin
            @(negedge clock);
            check_idle_outputs();
        end
        @(posedge clock);
        arst_n <= 1'b1;
        repeat (2) begin
            @(negedge clock);
            check_idle_outputs();
        end
        report_test("reset");

        // Mixed loads and stores with random hold
        start_test();
        for (int i = 0; i < 200; i++) begin
            random_access(1'($urandom_range(1)), $urandom_range(4));
        end
        report_test("handshake");

        // Partial stores, then loads of the same window
        start_test();
        repeat (64) random_access(1'b1, 0);
        repeat (64) random_access(1'b0, 0);
        report_test("byte_write");

        start_test();
        wait_frame_start();
        check_frame(1'b0);
        report_test("sync");

        // Every visible line gets random content
        start_test();
        for (int a = 0; a < FRAME_WORDS; a++) begin
            cmd.we      = 1'b1;
            cmd.addr    = 14'(a);
            cmd.byteena = 4'hf;
            cmd.wdata   = $urandom;
            core_access(cmd, 0);
        end
        wait_frame_start();
        check_frame(1'b1);
        report_test("pixel");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
